/* verilog/ex_pkg.sv */
`default_nettype none

package ex_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  localparam int unsigned XLEN       = 32;  // Data word
  localparam int unsigned LANE_W     = 16;  // One vector lane
  localparam int unsigned REG_ADDR_W = 5;   // Register file address
  localparam int unsigned EX_OP_W    = 4;

  //////////////////////////////
  // Operation codes
  //////////////////////////////

  // ALU ops, bit 3 clear
  localparam logic [EX_OP_W-1:0] OP_ADD  = 4'd0;
  localparam logic [EX_OP_W-1:0] OP_SUB  = 4'd1;
  localparam logic [EX_OP_W-1:0] OP_AND  = 4'd2;
  localparam logic [EX_OP_W-1:0] OP_OR   = 4'd3;
  localparam logic [EX_OP_W-1:0] OP_XOR  = 4'd4;
  localparam logic [EX_OP_W-1:0] OP_SLL  = 4'd5;
  localparam logic [EX_OP_W-1:0] OP_SRL  = 4'd6;
  localparam logic [EX_OP_W-1:0] OP_SLTU = 4'd7;   // Unsigned compare, 0 or 1

  // Multiplier ops, bit 3 set
  localparam logic [EX_OP_W-1:0] OP_MUL  = 4'd8;   // Low word of a*b
  localparam logic [EX_OP_W-1:0] OP_MAC  = 4'd9;   // a*b + c
  // Codes 10 to 15 reserved

  //////////////////////////////
  // Word and lane views
  //////////////////////////////

  // Lane 1 sits in the high half
  typedef union packed {
    logic [XLEN-1:0]             word;
    logic [1:0][LANE_W-1:0]      lanes;
  } ex_word_u;

endpackage

`default_nettype wire

/* verilog/ex_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       alu_en_i,      // One pulse per accepted op
  input  logic [ex_pkg::EX_OP_W-1:0] op_i,
  input  logic                       vec_mode_i,    // Split add/sub into two lanes
  input  ex_pkg::ex_word_u           operand_a_i,
  input  ex_pkg::ex_word_u           operand_b_i,
  output ex_pkg::ex_word_u           alu_result_o   // Valid the cycle after enable
);

  import ex_pkg::*;

  ex_word_u                   lane_sum;     // Per lane add
  ex_word_u                   lane_diff;    // Per lane subtract
  ex_word_u                   result_d;
  logic [$clog2(XLEN)-1:0]    shamt;        // Low bits of b only

  assign shamt = operand_b_i.word[$clog2(XLEN)-1:0];

  //////////////////////////////
  // Vector lanes
  //////////////////////////////

  // Each lane wraps by itself
  always_comb begin
    for (int i = 0; i < XLEN / LANE_W; i++) begin
      lane_sum.lanes[i]  = operand_a_i.lanes[i] + operand_b_i.lanes[i];
      lane_diff.lanes[i] = operand_a_i.lanes[i] - operand_b_i.lanes[i];
    end
  end

  //////////////////////////////
  // Result select
  //////////////////////////////

  always_comb begin
    result_d.word = '0;   // Reserved codes give zero
    case (op_i)
      OP_ADD: begin
        if (vec_mode_i) begin
          result_d = lane_sum;
        end else begin
          result_d.word = operand_a_i.word + operand_b_i.word;
        end
      end
      OP_SUB: begin
        if (vec_mode_i) begin
          result_d = lane_diff;
        end else begin
          result_d.word = operand_a_i.word - operand_b_i.word;
        end
      end
      OP_AND:  result_d.word = operand_a_i.word & operand_b_i.word;
      OP_OR:   result_d.word = operand_a_i.word | operand_b_i.word;
      OP_XOR:  result_d.word = operand_a_i.word ^ operand_b_i.word;
      OP_SLL:  result_d.word = operand_a_i.word << shamt;
      OP_SRL:  result_d.word = operand_a_i.word >> shamt;   // Zero fill
      OP_SLTU: begin
        // Single flag bit, rest zero
        result_d.word = {{(XLEN-1){1'b0}}, (operand_a_i.word < operand_b_i.word)};
      end
      default: result_d.word = '0;
    endcase
  end

  // Holds last result between enables
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      alu_result_o <= '0;
    end else if (alu_en_i) begin
      alu_result_o <= result_d;
    end
  end

endmodule

`default_nettype wire

/* verilog/ex_mult.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_mult (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       mult_en_i,     // One pulse per accepted op
  input  logic [ex_pkg::EX_OP_W-1:0] op_i,          // MUL or MAC
  input  logic                       vec_mode_i,    // Two 16 bit lane products
  input  ex_pkg::ex_word_u           operand_a_i,
  input  ex_pkg::ex_word_u           operand_b_i,
  input  ex_pkg::ex_word_u           operand_c_i,   // Accumulator, MAC only
  output ex_pkg::ex_word_u           mult_result_o  // Two cycles after enable
);

  import ex_pkg::*;

  // Stage 1
  ex_word_u   prod_d;
  ex_word_u   prod_q;
  ex_word_u   c_q;
  logic       mac_q;      // Add c in stage 2
  logic       vec_q;
  logic       s1_v_q;

  // Stage 2
  ex_word_u   acc_d;
  ex_word_u   res_q;
  logic       s2_v_q;

  //////////////////////////////
  // Stage 1 products
  //////////////////////////////

  always_comb begin
    if (vec_mode_i) begin
      // Truncated to lane width
      for (int i = 0; i < XLEN / LANE_W; i++) begin
        prod_d.lanes[i] = operand_a_i.lanes[i] * operand_b_i.lanes[i];
      end
    end else begin
      prod_d.word = operand_a_i.word * operand_b_i.word;   // Low word kept
    end
  end

  always_ff @(posedge clk) begin
    if (mult_en_i) begin
      prod_q <= prod_d;
      c_q    <= operand_c_i;
      mac_q  <= (op_i == OP_MAC);
      vec_q  <= vec_mode_i;
    end
  end

  //////////////////////////////
  // Stage 2 accumulate
  //////////////////////////////

  always_comb begin
    acc_d = prod_q;   // Plain MUL passes through
    if (mac_q) begin
      if (vec_q) begin
        for (int i = 0; i < XLEN / LANE_W; i++) begin
          acc_d.lanes[i] = prod_q.lanes[i] + c_q.lanes[i];   // No carry across lanes
        end
      end else begin
        acc_d.word = prod_q.word + c_q.word;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s1_v_q) begin
      res_q <= acc_d;
    end
  end

  // Valid bits track occupancy of each stage
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s1_v_q <= 1'b0;
      s2_v_q <= 1'b0;
    end else begin
      s1_v_q <= mult_en_i;
      s2_v_q <= s1_v_q;
    end
  end

  // Zero when stage 2 is empty
  assign mult_result_o = s2_v_q ? res_q : '0;

endmodule

`default_nettype wire

/* verilog/ex_dispatch_wb.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_dispatch_wb (
  input  logic                          clk,
  input  logic                          rst_n_i,

  // Issue side
  input  logic                          valid_i,
  input  logic [ex_pkg::EX_OP_W-1:0]    op_i,
  input  logic [ex_pkg::REG_ADDR_W-1:0] waddr_i,
  output logic                          ready_o,

  // Unit enables
  output logic                          alu_en_o,
  output logic                          mult_en_o,

  // Unit results
  input  ex_pkg::ex_word_u              alu_result_i,
  input  ex_pkg::ex_word_u              mult_result_i,

  // Register file write port
  output logic                          wb_we_o,
  output logic [ex_pkg::REG_ADDR_W-1:0] wb_waddr_o,
  output logic [ex_pkg::XLEN-1:0]       wb_wdata_o
);

  import ex_pkg::*;

  logic                    is_mult;       // Bit 3 marks the multiplier
  logic                    accept;

  // ALU track, 1 deep
  logic                    alu_v_q;
  logic [REG_ADDR_W-1:0]   alu_waddr_q;

  // Multiplier track, 2 deep, index 1 is the output end
  logic [1:0]                   mult_v_q;
  logic [1:0][REG_ADDR_W-1:0]   mult_waddr_q;

  //////////////////////////////
  // Issue and ready
  //////////////////////////////

  assign is_mult = op_i[EX_OP_W-1];

  // ALU right behind a MUL/MAC would land on the same write cycle
  assign ready_o   = !(valid_i && !is_mult && mult_v_q[0]);
  assign accept    = valid_i & ready_o;
  assign alu_en_o  = accept & ~is_mult;
  assign mult_en_o = accept & is_mult;

  //////////////////////////////
  // Destination tracking
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      alu_v_q  <= 1'b0;
      mult_v_q <= 2'b00;
    end else begin
      alu_v_q  <= alu_en_o;
      mult_v_q <= {mult_v_q[0], mult_en_o};   // Shift towards write port
    end
  end

  // Addresses follow the valid bits
  always_ff @(posedge clk) begin
    if (alu_en_o) begin
      alu_waddr_q <= waddr_i;
    end
    if (mult_en_o) begin
      mult_waddr_q[0] <= waddr_i;
    end
    if (mult_v_q[0]) begin
      mult_waddr_q[1] <= mult_waddr_q[0];
    end
  end

  //////////////////////////////
  // Write port merge
  //////////////////////////////

  // At most one track valid per cycle
  assign wb_we_o    = alu_v_q | mult_v_q[1];
  assign wb_waddr_o = mult_v_q[1] ? mult_waddr_q[1] : alu_waddr_q;
  assign wb_wdata_o = mult_v_q[1] ? mult_result_i.word : alu_result_i.word;

endmodule

`default_nettype wire

/* verilog/ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
  input  logic                          clk,
  input  logic                          rst_n_i,

  // Operation in
  input  logic                          valid_i,
  input  logic [ex_pkg::EX_OP_W-1:0]    op_i,
  input  logic                          vec_mode_i,
  input  ex_pkg::ex_word_u              operand_a_i,
  input  ex_pkg::ex_word_u              operand_b_i,
  input  ex_pkg::ex_word_u              operand_c_i,   // MAC accumulator
  input  logic [ex_pkg::REG_ADDR_W-1:0] waddr_i,
  output logic                          ready_o,       // Only stall source

  // Register file write port
  output logic                          wb_we_o,
  output logic [ex_pkg::REG_ADDR_W-1:0] wb_waddr_o,
  output logic [ex_pkg::XLEN-1:0]       wb_wdata_o
);

  import ex_pkg::*;

  logic       alu_en;
  logic       mult_en;
  ex_word_u   alu_result;    // 1 cycle after alu_en
  ex_word_u   mult_result;   // 2 cycles after mult_en

  //////////////////////////////
  // ALU
  //////////////////////////////

  ex_alu alu_i (
    .clk           ( clk          ),
    .rst_n_i       ( rst_n_i      ),
    .alu_en_i      ( alu_en       ),
    .op_i          ( op_i         ),
    .vec_mode_i    ( vec_mode_i   ),
    .operand_a_i   ( operand_a_i  ),
    .operand_b_i   ( operand_b_i  ),
    .alu_result_o  ( alu_result   )
  );

  //////////////////////////////
  // Multiplier
  //////////////////////////////

  ex_mult mult_i (
    .clk           ( clk          ),
    .rst_n_i       ( rst_n_i      ),
    .mult_en_i     ( mult_en      ),
    .op_i          ( op_i         ),
    .vec_mode_i    ( vec_mode_i   ),
    .operand_a_i   ( operand_a_i  ),
    .operand_b_i   ( operand_b_i  ),
    .operand_c_i   ( operand_c_i  ),
    .mult_result_o ( mult_result  )
  );

  //////////////////////////////
  // Dispatch and write-back
  //////////////////////////////

  ex_dispatch_wb dispatch_wb_i (
    .clk           ( clk          ),
    .rst_n_i       ( rst_n_i      ),
    .valid_i       ( valid_i      ),
    .op_i          ( op_i         ),
    .waddr_i       ( waddr_i      ),
    .ready_o       ( ready_o      ),
    .alu_en_o      ( alu_en       ),   // To ALU
    .mult_en_o     ( mult_en      ),   // To multiplier
    .alu_result_i  ( alu_result   ),
    .mult_result_i ( mult_result  ),
    .wb_we_o       ( wb_we_o      ),
    .wb_waddr_o    ( wb_waddr_o   ),
    .wb_wdata_o    ( wb_wdata_o   )
  );

endmodule

`default_nettype wire

/* dv/ex_stage_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_stage_assert (
  input  logic                          clk,
  input  logic                          rst_n_i,
  input  logic                          valid_i,
  input  logic [ex_pkg::EX_OP_W-1:0]    op_i,
  input  logic                          vec_mode_i,
  input  ex_pkg::ex_word_u              operand_a_i,
  input  ex_pkg::ex_word_u              operand_b_i,
  input  ex_pkg::ex_word_u              operand_c_i,
  input  logic [ex_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic                          ready_i,     // Stage ready_o
  input  logic                          wb_we_i,
  input  logic [ex_pkg::REG_ADDR_W-1:0] wb_waddr_i,
  input  logic [ex_pkg::XLEN-1:0]       wb_wdata_i
);

  import ex_pkg::*;

  int unsigned                  fail_cnt = 0;    // Read by the testbench

  logic                         accept_alu;
  logic                         accept_mult;
  logic                         post_rst_q;      // Low in reset and first edge after
  logic                         exp_alu_v_q;
  logic [REG_ADDR_W-1:0]        exp_alu_addr_q;
  ex_word_u                     exp_alu_data_q;
  logic [1:0]                   exp_mult_v_q;    // Index 1 due at the write port
  logic [1:0][REG_ADDR_W-1:0]   exp_mult_addr_q;
  ex_word_u                     exp_mult_data_q [2];
  logic                         exp_we;
  logic [REG_ADDR_W-1:0]        exp_waddr;
  logic [XLEN-1:0]              exp_wdata;

  //////////////////////////////
  // Reference results
  //////////////////////////////

  function automatic ex_word_u alu_ref(input logic [EX_OP_W-1:0] op, input logic vec,
                                       input ex_word_u a, input ex_word_u b);
    ex_word_u r;
    r.word = '0;
    case (op)
      OP_ADD:  r.word = vec ? {a.lanes[1] + b.lanes[1], a.lanes[0] + b.lanes[0]}
                            : a.word + b.word;
      OP_SUB:  r.word = vec ? {a.lanes[1] - b.lanes[1], a.lanes[0] - b.lanes[0]}
                            : a.word - b.word;
      OP_AND:  r.word = a.word & b.word;
      OP_OR:   r.word = a.word | b.word;
      OP_XOR:  r.word = a.word ^ b.word;
      OP_SLL:  r.word = a.word << b.word[4:0];   // Shift amount 0 to 31
      OP_SRL:  r.word = a.word >> b.word[4:0];
      OP_SLTU: r.word = (a.word < b.word) ? 32'd1 : 32'd0;
      default: r.word = '0;
    endcase
    return r;
  endfunction

  function automatic ex_word_u mult_ref(input logic [EX_OP_W-1:0] op, input logic vec,
                                        input ex_word_u a, input ex_word_u b,
                                        input ex_word_u c);
    ex_word_u         r;
    logic [LANE_W-1:0] p0;
    logic [LANE_W-1:0] p1;
    if (vec) begin
      p0 = a.lanes[0] * b.lanes[0];   // Lane products cut to 16 bits
      p1 = a.lanes[1] * b.lanes[1];
      if (op == OP_MAC) begin
        p0 = p0 + c.lanes[0];
        p1 = p1 + c.lanes[1];
      end
      r.word = {p1, p0};
    end else begin
      r.word = a.word * b.word + ((op == OP_MAC) ? c.word : 32'd0);
    end
    return r;
  endfunction

  //////////////////////////////
  // Expected write stream
  //////////////////////////////

  assign accept_alu  = valid_i && ready_i && !op_i[EX_OP_W-1];
  assign accept_mult = valid_i && ready_i && op_i[EX_OP_W-1];

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      post_rst_q   <= 1'b0;
      exp_alu_v_q  <= 1'b0;
      exp_mult_v_q <= 2'b00;
    end else begin
      post_rst_q   <= 1'b1;
      exp_alu_v_q  <= accept_alu;
      exp_mult_v_q <= {exp_mult_v_q[0], accept_mult};
    end
  end

  always_ff @(posedge clk) begin
    if (accept_alu) begin
      exp_alu_addr_q <= waddr_i;
      exp_alu_data_q <= alu_ref(op_i, vec_mode_i, operand_a_i, operand_b_i);
    end
    if (accept_mult) begin
      exp_mult_addr_q[0] <= waddr_i;
      exp_mult_data_q[0] <= mult_ref(op_i, vec_mode_i, operand_a_i, operand_b_i, operand_c_i);
    end
    exp_mult_addr_q[1] <= exp_mult_addr_q[0];   // Second multiplier stage
    exp_mult_data_q[1] <= exp_mult_data_q[0];
  end

  assign exp_we    = exp_alu_v_q | exp_mult_v_q[1];
  assign exp_waddr = exp_mult_v_q[1] ? exp_mult_addr_q[1] : exp_alu_addr_q;
  assign exp_wdata = exp_mult_v_q[1] ? exp_mult_data_q[1].word : exp_alu_data_q.word;

  //////////////////////////////
  // Assertions
  //////////////////////////////

  a_reset_quiet: assert property (@(posedge clk) !post_rst_q |-> (!wb_we_i && ready_i))
    else begin
      fail_cnt++;
      $error("[FAIL] reset: wb_we_o %h ready_o %h, expected 0 and 1",
             $sampled(wb_we_i), $sampled(ready_i));
    end

  // Stall only for ALU work right after a multiplier accept
  a_ready_rule: assert property (@(posedge clk) disable iff (!rst_n_i)
      ready_i == !(valid_i && !op_i[EX_OP_W-1] && exp_mult_v_q[0]))
    else begin
      fail_cnt++;
      $error("[FAIL] ready_o expected %h got %h",
             $sampled(!(valid_i && !op_i[EX_OP_W-1] && exp_mult_v_q[0])), $sampled(ready_i));
    end

  a_we: assert property (@(posedge clk) disable iff (!rst_n_i) wb_we_i == exp_we)
    else begin
      fail_cnt++;
      $error("[FAIL] wb_we_o expected %h got %h", $sampled(exp_we), $sampled(wb_we_i));
    end

  a_waddr: assert property (@(posedge clk) disable iff (!rst_n_i)
      exp_we |-> wb_waddr_i == exp_waddr)
    else begin
      fail_cnt++;
      $error("[FAIL] wb_waddr_o expected %h got %h", $sampled(exp_waddr), $sampled(wb_waddr_i));
    end

  a_wdata: assert property (@(posedge clk) disable iff (!rst_n_i)
      exp_we |-> wb_wdata_i == exp_wdata)
    else begin
      fail_cnt++;
      $error("[FAIL] wb_wdata_o expected %h got %h", $sampled(exp_wdata), $sampled(wb_wdata_i));
    end

endmodule

bind ex_stage ex_stage_assert assert_i (
  .clk         ( clk         ),
  .rst_n_i     ( rst_n_i     ),
  .valid_i     ( valid_i     ),
  .op_i        ( op_i        ),
  .vec_mode_i  ( vec_mode_i  ),
  .operand_a_i ( operand_a_i ),
  .operand_b_i ( operand_b_i ),
  .operand_c_i ( operand_c_i ),
  .waddr_i     ( waddr_i     ),
  .ready_i     ( ready_o     ),
  .wb_we_i     ( wb_we_o     ),
  .wb_waddr_i  ( wb_waddr_o  ),
  .wb_wdata_i  ( wb_wdata_o  )
);

`default_nettype wire

/* dv/tb_ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage;

  import ex_pkg::*;

  localparam int unsigned NUM_OPS      = 400;
  localparam int unsigned RESET_CYCLES = 10;
  // Two issue cycles per op at worst, plus idle gaps, reset and drain
  localparam int unsigned MAX_CYCLES   = NUM_OPS * 5;

  logic                   clk;
  logic                   rst_n_i;
  logic                   valid_i;
  logic [EX_OP_W-1:0]     op_i;
  logic                   vec_mode_i;
  ex_word_u               operand_a_i;
  ex_word_u               operand_b_i;
  ex_word_u               operand_c_i;
  logic [REG_ADDR_W-1:0]  waddr_i;
  logic                   ready_o;
  logic                   wb_we_o;
  logic [REG_ADDR_W-1:0]  wb_waddr_o;
  logic [XLEN-1:0]        wb_wdata_o;

  logic [31:0]            rng_state;
  int unsigned            cycle_cnt;
  int unsigned            ops_issued;
  int unsigned            writes_seen;
  int unsigned            stall_cnt;     // Cycles with ready_o low

  ex_stage dut_i (
    .clk         ( clk         ),
    .rst_n_i     ( rst_n_i     ),
    .valid_i     ( valid_i     ),
    .op_i        ( op_i        ),
    .vec_mode_i  ( vec_mode_i  ),
    .operand_a_i ( operand_a_i ),
    .operand_b_i ( operand_b_i ),
    .operand_c_i ( operand_c_i ),
    .waddr_i     ( waddr_i     ),
    .ready_o     ( ready_o     ),
    .wb_we_o     ( wb_we_o     ),
    .wb_waddr_o  ( wb_waddr_o  ),
    .wb_wdata_o  ( wb_wdata_o  )
  );

  always #4 clk = ~clk;   // 8 ns period

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_rand(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r = rng_state;
  endtask

  // Offer one op and hold it until accepted
  task automatic issue_op(input logic [EX_OP_W-1:0] op, input logic vec,
                          input logic [31:0] a, input logic [31:0] b,
                          input logic [31:0] c, input logic [REG_ADDR_W-1:0] waddr);
    @(negedge clk);
    valid_i          = 1'b1;
    op_i             = op;
    vec_mode_i       = vec;
    operand_a_i.word = a;
    operand_b_i.word = b;
    operand_c_i.word = c;
    waddr_i          = waddr;
    @(posedge clk);
    while (!ready_o) begin   // Value from before the edge
      stall_cnt++;
      @(posedge clk);
    end
    ops_issued++;
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    valid_i = 1'b0;
  endtask

  task automatic finish_run(input logic timed_out);
    int unsigned errors;
    errors = dut_i.assert_i.fail_cnt + (timed_out ? 1 : 0);
    $display("Ops issued %0d, writes %0d, stalls %0d, errors %0d",
             ops_issued, writes_seen, stall_cnt, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  endtask

  //////////////////////////////
  // Monitors and timeout
  //////////////////////////////

  always @(posedge clk) begin
    if (rst_n_i && wb_we_o) begin
      writes_seen++;
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      finish_run(1'b1);
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    logic [31:0]        r;
    logic [31:0]        a;
    logic [31:0]        b;
    logic [31:0]        c;
    logic [EX_OP_W-1:0] op;
    clk              = 1'b0;
    rst_n_i          = 1'b0;
    valid_i          = 1'b0;
    op_i             = OP_ADD;
    vec_mode_i       = 1'b0;
    operand_a_i.word = '0;
    operand_b_i.word = '0;
    operand_c_i.word = '0;
    waddr_i          = '0;
    rng_state        = 32'h3deb_fe13;
    cycle_cnt        = 0;
    ops_issued       = 0;
    writes_seen      = 0;
    stall_cnt        = 0;

    repeat (RESET_CYCLES) @(negedge clk);
    rst_n_i = 1'b1;
    idle_cycle();   // Quiet cycle straight after reset

    for (int i = 0; i < NUM_OPS; i++) begin
      next_rand(r);
      if (r[2:0] == 3'd0) begin
        idle_cycle();   // Occasional gap
      end
      next_rand(r);
      // Half multiplier ops, so ALU-after-MUL stalls come often
      op = r[0] ? (r[1] ? OP_MAC : OP_MUL) : {1'b0, r[4:2]};
      next_rand(a);
      next_rand(b);
      next_rand(c);
      issue_op(op, r[5], a, b, c, r[10:6]);
    end
    idle_cycle();

    // Drain until every accepted op has been written
    while (writes_seen < ops_issued) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);   // Idle cycles must stay write-free
    finish_run(1'b0);
  end

endmodule

`default_nettype wire

/* build.f */
verilog/ex_pkg.sv
verilog/ex_alu.sv
verilog/ex_mult.sv
verilog/ex_dispatch_wb.sv
verilog/ex_stage.sv
dv/ex_stage_assert.sv
dv/tb_ex_stage.sv
